//--- sim.f
linemult_pkg.sv
line_buffer.sv
scanline_strength.sv
scanline_mixer.sv
linemult_top.sv
tb_clock_gen.sv
tb_linemult.sv

//--- Bender.yml
package:
  name: linemult

sources:
  - linemult_pkg.sv
  - line_buffer.sv
  - scanline_strength.sv
  - scanline_mixer.sv
  - linemult_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_linemult.sv

//--- tb_linemult.sv
// runs with LINE_PIXELS of 16 and two pages and samples outputs on the falling clock edge
`timescale 1ns/10ps

module tb_linemult;

  import linemult_pkg::*;

  localparam int          LINE_PIXELS = 16;
  localparam logic [31:0] SEED        = 32'h9e4d;
  localparam int          NUM_LINES   = 4;     // complete lines per round
  localparam int          TIMEOUT     = 2000;  // cycles allowed for any wait

  logic      VCLK_o;
  logic      nVRST_o;
  logic      lm_en_i;
  logic      sl_en_i;
  strength_t sl_str_i;
  hyb_t      sl_hyb_i;
  logic      vdata_valid_i;
  logic      line_start_i;
  pixel_t    vdata_i;
  logic      vdata_valid_o;
  logic      line_start_o;
  pixel_t    vdata_o;

  logic [31:0] lfsr;
  pixel_t      line_px [LINE_PIXELS];  // last line sent
  pixel_t      exp_px_q [$];
  logic        exp_ls_q [$];
  string       test_name;
  int          value_errors;
  int          other_errors;
  int          lines_done;             // complete lines sent with doubling on
  logic        prev_lm_en;             // inputs seen one cycle earlier
  logic        prev_valid;
  logic        prev_ls;
  pixel_t      prev_px;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock_gen (
    .VCLK_o  (VCLK_o),
    .nVRST_o (nVRST_o)
  );

  linemult_top #(.LINE_PIXELS(LINE_PIXELS), .NUM_PAGES(2)) UUT (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .lm_en_i       (lm_en_i),
    .sl_en_i       (sl_en_i),
    .sl_str_i      (sl_str_i),
    .sl_hyb_i      (sl_hyb_i),
    .vdata_valid_i (vdata_valid_i),
    .line_start_i  (line_start_i),
    .vdata_i       (vdata_i),
    .vdata_valid_o (vdata_valid_o),
    .line_start_o  (line_start_o),
    .vdata_o       (vdata_o)
  );

  ////////////////////////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < n; k++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // bright pixels reduce the configured strength
  function automatic int scan_factor(pixel_t px, strength_t str, hyb_t hyb);
    int luma;
    int y_ref;
    luma  = int'(px[23:16]) + 2 * int'(px[15:8]) + int'(px[7:0]);
    y_ref = (((luma * int'(hyb)) / 32) * int'(str)) / 256;
    return (int'(str) < y_ref) ? 255 : 255 - (int'(str) - y_ref);
  endfunction

  function automatic pixel_t darken(pixel_t px, int factor);
    pixel_t res;
    for (int ch = 0; ch < 3; ch++)
      res[ch*COLOR_W +: COLOR_W] = (int'(px[ch*COLOR_W +: COLOR_W]) * factor) / 256;
    return res;
  endfunction

  task automatic push_doubled();
    for (int c = 0; c < 2; c++) begin
      for (int i = 0; i < LINE_PIXELS; i++) begin
        if (c == 1 && sl_en_i)
          exp_px_q.push_back(darken(line_px[i], scan_factor(line_px[i], sl_str_i, sl_hyb_i)));
        else
          exp_px_q.push_back(line_px[i]);
        exp_ls_q.push_back(i == 0);
      end
    end
    lines_done++;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and waits

  task automatic send_line(input int n_pixels, input bit bright);
    logic [31:0] bits;
    for (int i = 0; i < n_pixels; i++) begin
      draw_bits(24, bits);
      line_px[i]     = bright ? (pixel_t'(bits) | 24'hc0c0c0) : pixel_t'(bits);
      vdata_valid_i <= 1'b1;
      line_start_i  <= (i == 0);
      vdata_i       <= line_px[i];
      @(posedge VCLK_o);
      vdata_valid_i <= 1'b0;
      line_start_i  <= 1'b0;
      if (i == LINE_PIXELS-1 && lm_en_i)
        push_doubled();
      draw_bits(1, bits);
      repeat (bits[0] ? 2 : 1) @(posedge VCLK_o);  // spacing of 2 or 3 cycles
    end
  endtask

  task automatic configure(input logic lm_en, input logic sl_en, input strength_t str,
                           input hyb_t hyb);
    lm_en_i  <= lm_en;
    sl_en_i  <= sl_en;
    sl_str_i <= str;
    sl_hyb_i <= hyb;
    @(posedge VCLK_o);
  endtask

  task automatic finish_run();
    $display("error count: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (nVRST_o !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge VCLK_o);
      cycles++;
    end
    if (nVRST_o !== 1'b1) begin
      other_errors++;
      $display("ERROR: reset was never released");
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_px_q.size() != 0 && cycles < TIMEOUT) begin
      @(posedge VCLK_o);
      cycles++;
    end
    if (exp_px_q.size() != 0) begin
      other_errors++;
      $display("ERROR: %s timed out with %0d pixels never output", test_name, exp_px_q.size());
      exp_px_q.delete();  // next round starts from an empty model
      exp_ls_q.delete();
    end
    repeat (4) @(posedge VCLK_o);  // let the pipeline settle before new settings
  endtask

  task automatic run_round(input logic sl_en, input strength_t str, input hyb_t hyb,
                           input bit bright);
    configure(1'b1, sl_en, str, hyb);
    repeat (NUM_LINES) send_line(LINE_PIXELS, bright);
    wait_drained();
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor

  always @(negedge VCLK_o) begin
    pixel_t exp_px;
    logic   exp_ls;
    if (lines_done == 0) begin
      if (nVRST_o === 1'b1) begin  // quiet from reset release to the first full line
        assert (vdata_valid_o === 1'b0 && line_start_o === 1'b0) else begin
          other_errors++;
          $display("ERROR: output active before the first complete line");
        end
      end
    end else if (!prev_lm_en) begin  // bypass is the input one cycle later
      assert (vdata_valid_o === prev_valid && line_start_o === prev_ls &&
              (!prev_valid || vdata_o === prev_px)) else begin
        value_errors++;
        $display("FAILED %s: expected valid %b start %b pixel %h, actual %b %b %h",
                 test_name, prev_valid, prev_ls, prev_px, vdata_valid_o, line_start_o, vdata_o);
      end
    end else if (vdata_valid_o === 1'b1) begin
      assert (exp_px_q.size() != 0) else begin
        other_errors++;
        $display("ERROR: %s output a pixel when none was expected", test_name);
      end
      if (exp_px_q.size() != 0) begin
        exp_px = exp_px_q.pop_front();
        exp_ls = exp_ls_q.pop_front();
        assert (vdata_o === exp_px && line_start_o === exp_ls) else begin
          value_errors++;
          $display("FAILED %s: expected pixel %h start %b, actual pixel %h start %b",
                   test_name, exp_px, exp_ls, vdata_o, line_start_o);
        end
      end
    end else begin
      assert (line_start_o !== 1'b1) else begin
        other_errors++;
        $display("ERROR: %s raised line_start_o without vdata_valid_o", test_name);
      end
    end
    prev_lm_en = lm_en_i;
    prev_valid = vdata_valid_i;
    prev_ls    = line_start_i;
    prev_px    = vdata_i;
  end

  initial begin
    logic [31:0] bits;
    lfsr          = SEED;
    value_errors  = 0;
    other_errors  = 0;
    lines_done    = 0;
    lm_en_i       = 1'b1;
    sl_en_i       = 1'b0;
    sl_str_i      = '0;
    sl_hyb_i      = '0;
    vdata_valid_i = 1'b0;
    line_start_i  = 1'b0;
    vdata_i       = '0;
    test_name     = "reset";
    wait_for_reset();

    test_name = "doubling";
    run_round(1'b0, '0, '0, 1'b0);

    test_name = "fixed strength";
    repeat (2) begin
      draw_bits(8, bits);
      run_round(1'b1, bits[7:0], '0, 1'b0);
    end

    test_name = "hybrid strength";
    repeat (3) begin
      draw_bits(13, bits);
      run_round(1'b1, bits[7:0], bits[12:8], 1'b0);
    end
    draw_bits(8, bits);
    run_round(1'b1, bits[7:0], 5'd31, 1'b1);  // bright pixels at full depth stay at 255

    test_name = "short line";
    configure(1'b1, 1'b0, '0, '0);
    draw_bits(4, bits);
    send_line(1 + int'(bits[3:0]) % (LINE_PIXELS-1), 1'b0);
    send_line(LINE_PIXELS, 1'b0);
    wait_drained();

    test_name = "bypass";
    configure(1'b0, 1'b0, '0, '0);
    send_line(LINE_PIXELS, 1'b0);
    send_line(LINE_PIXELS / 2, 1'b0);
    repeat (3) @(posedge VCLK_o);
    finish_run();
  end

endmodule

//--- tb_clock_gen.sv
// simulation only, reset is released with a non-blocking update on a rising edge
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic VCLK_o,
  output logic nVRST_o
);

  initial begin
    VCLK_o = 1'b0;
    forever #(PERIOD_NS/2) VCLK_o = ~VCLK_o;
  end

  initial begin
    nVRST_o = 1'b0;  // held low for RESET_CYCLES rising edges
    repeat (RESET_CYCLES) @(posedge VCLK_o);
    nVRST_o <= 1'b1;
  end

endmodule

//--- linemult_top.sv
// single clock domain with no back-pressure and configuration held stable while lines are in flight
`timescale 1ns/10ps

module linemult_top #(
  parameter int LINE_PIXELS = 640,  // at least 4
  parameter int NUM_PAGES   = 2     // at least 2
) (
  input  logic                    VCLK_o,
  input  logic                    nVRST_o,
  input  logic                    lm_en_i,
  input  logic                    sl_en_i,
  input  linemult_pkg::strength_t sl_str_i,
  input  linemult_pkg::hyb_t      sl_hyb_i,
  input  logic                    vdata_valid_i,
  input  logic                    line_start_i,
  input  linemult_pkg::pixel_t    vdata_i,
  output logic                    vdata_valid_o,
  output logic                    line_start_o,
  output linemult_pkg::pixel_t    vdata_o
);

  import linemult_pkg::*;

  logic      rd_valid;
  logic      rd_line_start;
  copy_t     rd_copy;
  pixel_t    rd_pixel;
  strength_t sl_factor;  // STR_LAT cycles behind rd_pixel

  line_buffer #(
    .LINE_PIXELS (LINE_PIXELS),
    .NUM_PAGES   (NUM_PAGES)
  ) u_line_buffer (
    .VCLK_o          (VCLK_o),
    .nVRST_o         (nVRST_o),
    .lm_en_i         (lm_en_i),
    .vdata_valid_i   (vdata_valid_i),
    .line_start_i    (line_start_i),
    .vdata_i         (vdata_i),
    .rd_valid_o      (rd_valid),
    .rd_line_start_o (rd_line_start),
    .rd_copy_o       (rd_copy),
    .rd_pixel_o      (rd_pixel)
  );

  scanline_strength u_scanline_strength (
    .VCLK_o      (VCLK_o),
    .nVRST_o     (nVRST_o),
    .sl_str_i    (sl_str_i),
    .sl_hyb_i    (sl_hyb_i),
    .rd_pixel_i  (rd_pixel),
    .sl_factor_o (sl_factor)
  );

  scanline_mixer u_scanline_mixer (
    .VCLK_o          (VCLK_o),
    .nVRST_o         (nVRST_o),
    .lm_en_i         (lm_en_i),
    .sl_en_i         (sl_en_i),
    .rd_valid_i      (rd_valid),
    .rd_line_start_i (rd_line_start),
    .rd_copy_i       (rd_copy),
    .rd_pixel_i      (rd_pixel),
    .sl_factor_i     (sl_factor),
    .vdata_valid_i   (vdata_valid_i),
    .line_start_i    (line_start_i),
    .vdata_i         (vdata_i),
    .vdata_valid_o   (vdata_valid_o),
    .line_start_o    (line_start_o),
    .vdata_o         (vdata_o)
  );

endmodule

//--- scanline_mixer.sv
// bypass switches on lm_en_i directly so the configuration must only change while the output is idle
`timescale 1ns/10ps

module scanline_mixer (
  input  logic                    VCLK_o,
  input  logic                    nVRST_o,
  input  logic                    lm_en_i,
  input  logic                    sl_en_i,
  input  logic                    rd_valid_i,
  input  logic                    rd_line_start_i,
  input  linemult_pkg::copy_t     rd_copy_i,
  input  linemult_pkg::pixel_t    rd_pixel_i,
  input  linemult_pkg::strength_t sl_factor_i,
  input  logic                    vdata_valid_i,
  input  logic                    line_start_i,
  input  linemult_pkg::pixel_t    vdata_i,
  output logic                    vdata_valid_o,
  output logic                    line_start_o,
  output linemult_pkg::pixel_t    vdata_o
);

  import linemult_pkg::*;

  pixel_t             px_d [STR_LAT];  // pixel path waiting for its strength
  logic [STR_LAT-1:0] valid_d;
  logic [STR_LAT-1:0] ls_d;
  logic [STR_LAT-1:0] sel_d;           // scanline select
  pixel_t             px_m;
  logic               valid_m;
  logic               ls_m;

  function automatic color_t dim(color_t c, strength_t f);
    logic [COLOR_W+STR_W-1:0] prod;
    prod = c * f;
    return prod[COLOR_W+STR_W-1:STR_W];
  endfunction

  ////////////////////////////////////////////////////////////
  // alignment and flags

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      valid_d       <= '0;
      ls_d          <= '0;
      sel_d         <= '0;
      valid_m       <= 1'b0;
      ls_m          <= 1'b0;
      vdata_valid_o <= 1'b0;
      line_start_o  <= 1'b0;
    end else begin
      valid_d <= {valid_d[STR_LAT-2:0], rd_valid_i};
      ls_d    <= {ls_d[STR_LAT-2:0], rd_line_start_i};
      sel_d   <= {sel_d[STR_LAT-2:0], sl_en_i & rd_copy_i};  // only the second copy
      valid_m <= valid_d[STR_LAT-1];
      ls_m    <= ls_d[STR_LAT-1];
      if (lm_en_i) begin
        vdata_valid_o <= valid_m;
        line_start_o  <= ls_m;
      end else begin
        vdata_valid_o <= vdata_valid_i;  // bypass
        line_start_o  <= line_start_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pixel path

  always_ff @(posedge VCLK_o) begin
    px_d[0] <= rd_pixel_i;
    for (int i = 1; i < STR_LAT; i++)
      px_d[i] <= px_d[i-1];

    if (sel_d[STR_LAT-1])
      px_m <= {dim(px_d[STR_LAT-1][3*COLOR_W-1 -: COLOR_W], sl_factor_i),
               dim(px_d[STR_LAT-1][2*COLOR_W-1 -: COLOR_W], sl_factor_i),
               dim(px_d[STR_LAT-1][COLOR_W-1:0], sl_factor_i)};
    else
      px_m <= px_d[STR_LAT-1];

    vdata_o <= lm_en_i ? px_m : vdata_i;
  end

endmodule

//--- scanline_strength.sv
// latency is fixed at 4 cycles and strength and depth must stay stable while pixels are in flight
`timescale 1ns/10ps

module scanline_strength (
  input  logic                    VCLK_o,
  input  logic                    nVRST_o,
  input  linemult_pkg::strength_t sl_str_i,
  input  linemult_pkg::hyb_t      sl_hyb_i,
  input  linemult_pkg::pixel_t    rd_pixel_i,
  output linemult_pkg::strength_t sl_factor_o
);

  import linemult_pkg::*;

  color_t                  r;
  color_t                  g;
  color_t                  b;
  luma_t                   luma;
  logic [LUMA_W+HYB_W-1:0] y_hyb_full;
  logic [LUMA_W+STR_W-1:0] y_ref_full;
  luma_t                   y_hyb;   // stage 1
  luma_t                   y_ref;   // stage 2
  strength_t               sl_red;  // stage 3

  assign r = rd_pixel_i[3*COLOR_W-1 -: COLOR_W];
  assign g = rd_pixel_i[2*COLOR_W-1 -: COLOR_W];
  assign b = rd_pixel_i[COLOR_W-1:0];

  assign luma       = {2'b00, r} + {1'b0, g, 1'b0} + {2'b00, b};
  assign y_hyb_full = luma * sl_hyb_i;
  assign y_ref_full = y_hyb * sl_str_i;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      y_hyb       <= '0;
      y_ref       <= '0;
      sl_red      <= '0;
      sl_factor_o <= '1;  // full brightness
    end else begin
      y_hyb <= y_hyb_full[LUMA_W+HYB_W-1:HYB_W];  // luma scaled by depth / 32
      y_ref <= y_ref_full[LUMA_W+STR_W-1:STR_W];  // then by strength / 256

      // bright pixels eat into the configured strength
      if ({2'b00, sl_str_i} < y_ref)
        sl_red <= '0;
      else
        sl_red <= sl_str_i - y_ref[STR_W-1:0];

      sl_factor_o <= {STR_W{1'b1}} - sl_red;
    end
  end

endmodule

//--- line_buffer.sv
// input pixels must be at least two cycles apart since page overflow is never detected
`timescale 1ns/10ps

module line_buffer #(
  parameter int LINE_PIXELS = 640,
  parameter int NUM_PAGES   = 2
) (
  input  logic                 VCLK_o,
  input  logic                 nVRST_o,
  input  logic                 lm_en_i,
  input  logic                 vdata_valid_i,
  input  logic                 line_start_i,
  input  linemult_pkg::pixel_t vdata_i,
  output logic                 rd_valid_o,
  output logic                 rd_line_start_o,
  output linemult_pkg::copy_t  rd_copy_o,
  output linemult_pkg::pixel_t rd_pixel_o
);

  import linemult_pkg::*;

  localparam int ADDR_W = $clog2(LINE_PIXELS);
  localparam int CNT_W  = $clog2(LINE_PIXELS+1);
  localparam int PAGE_W = $clog2(NUM_PAGES);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PAGE_W-1:0] page_t;

  pixel_t mem [NUM_PAGES][LINE_PIXELS];  // one line per page

  logic [CNT_W-1:0]     wr_cnt;      // pixels seen in the current line
  logic                 wr_en;
  addr_t                wr_addr;
  pixel_t               wr_data;
  page_t                wr_page;
  logic [NUM_PAGES-1:0] page_ready;  // full lines waiting for the reader

  rd_state_t rd_state;
  page_t     rd_page;
  addr_t     rd_addr;

  wire wr_last  = wr_en && (wr_addr == addr_t'(LINE_PIXELS-1));
  wire rd_last  = rd_addr == addr_t'(LINE_PIXELS-1);
  wire rd_start = (rd_state == RD_IDLE) && page_ready[rd_page];

  function automatic page_t next_page(page_t pg);
    return (pg == page_t'(NUM_PAGES-1)) ? '0 : pg + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      wr_cnt <= '0;
      wr_en  <= 1'b0;
    end else if (!lm_en_i) begin
      wr_cnt <= '0;
      wr_en  <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (vdata_valid_i) begin
        if (line_start_i) begin  // a new line restarts the current page
          wr_cnt <= CNT_W'(1);
          wr_en  <= 1'b1;
        end else if (wr_cnt != '0 && wr_cnt < CNT_W'(LINE_PIXELS)) begin
          wr_cnt <= wr_cnt + 1'b1;
          wr_en  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (vdata_valid_i) begin
      wr_addr <= line_start_i ? '0 : addr_t'(wr_cnt);
      wr_data <= vdata_i;
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (wr_en)
      mem[wr_page][wr_addr] <= wr_data;  // one cycle after vdata_valid_i
  end

  // page hand-over between writer and reader
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      wr_page    <= '0;
      page_ready <= '0;
    end else if (!lm_en_i) begin
      wr_page    <= '0;
      page_ready <= '0;
    end else begin
      if (rd_start)
        page_ready[rd_page] <= 1'b0;
      if (wr_last) begin
        page_ready[wr_page] <= 1'b1;  // last pixel written so the line is complete
        wr_page             <= next_page(wr_page);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      rd_state <= RD_IDLE;
      rd_page  <= '0;
      rd_addr  <= '0;
    end else if (!lm_en_i) begin
      rd_state <= RD_IDLE;
      rd_page  <= '0;
      rd_addr  <= '0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          rd_addr <= '0;
          if (rd_start)
            rd_state <= RD_COPY0;
        end
        RD_COPY0: begin
          rd_addr <= rd_last ? '0 : rd_addr + 1'b1;
          if (rd_last)
            rd_state <= RD_COPY1;  // second copy follows without a gap
        end
        RD_COPY1: begin
          rd_addr <= rd_last ? '0 : rd_addr + 1'b1;
          if (rd_last) begin
            rd_state <= RD_IDLE;
            rd_page  <= next_page(rd_page);
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // flags follow the memory read latency
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      rd_valid_o      <= 1'b0;
      rd_line_start_o <= 1'b0;
      rd_copy_o       <= 1'b0;
    end else begin
      rd_valid_o      <= rd_state != RD_IDLE;
      rd_line_start_o <= (rd_state != RD_IDLE) && (rd_addr == '0);
      rd_copy_o       <= copy_t'(rd_state == RD_COPY1);
    end
  end

  always_ff @(posedge VCLK_o) begin
    rd_pixel_o <= mem[rd_page][rd_addr];
  end

endmodule

//--- linemult_pkg.sv
// color depth is fixed at 8 bits per channel because the strength arithmetic depends on it
package linemult_pkg;

  localparam int COLOR_W = 8;            // bits per color channel
  localparam int PIXEL_W = 3*COLOR_W;    // red on top and blue at the bottom
  localparam int LUMA_W  = COLOR_W + 2;  // r + 2g + b needs two extra bits
  localparam int STR_W   = 8;
  localparam int HYB_W   = 5;
  localparam int STR_LAT = 4;            // strength pipeline depth in cycles

  typedef logic [COLOR_W-1:0] color_t;
  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [LUMA_W-1:0]  luma_t;
  typedef logic [STR_W-1:0]   strength_t;  // 255 means no darkening
  typedef logic [HYB_W-1:0]   hyb_t;
  typedef logic               copy_t;      // copy index within a doubled line

  // read control of the line buffer
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_COPY0,
    RD_COPY1
  } rd_state_t;

endpackage
